//--- rtl/periph_consts.svh
/*
 * cluster event unit constants
 * bus widths, core count, event vector layout and address fields
 */

`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// peripheral bus
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_BE_W   4

// cores and request id (one id bit per core plus one master)
`define NB_CORES      8
`define PERIPH_ID_W   9

// event vector per core
`define EU_EVT_W      8
`define EU_ACC_EVT_W  4

// address layout: core index above the word offset
`define EU_CORE_LSB   4
`define EU_CORE_W     4
`define EU_OFS_LSB    2

`endif

//--- rtl/periph_bus_pkg.sv
/*
 * peripheral bus types
 * request and response of the cluster peripheral interconnect
 */

`default_nettype none

`include "periph_consts.svh"

package periph_bus_pkg;

  // response status
  typedef enum logic {
    OPC_OK  = 1'b0,
    OPC_ERR = 1'b1
  } periph_opc_e;

  // wen is active low, as on the cluster bus
  typedef struct packed {
    logic [`PERIPH_ADDR_W-1:0] add;
    logic                      wen;
    logic [`PERIPH_DATA_W-1:0] wdata;
    logic [`PERIPH_BE_W-1:0]   be;
    logic [`PERIPH_ID_W-1:0]   id;
  } periph_req_t;

  typedef struct packed {
    logic [`PERIPH_DATA_W-1:0] rdata;
    periph_opc_e               opc;
    logic [`PERIPH_ID_W-1:0]   id;
  } periph_resp_t;

endpackage

`default_nettype wire

//--- rtl/event_pkg.sv
/*
 * event unit types
 * per-core event vectors and the register offsets of the event buffer
 */

`default_nettype none

`include "periph_consts.svh"

package event_pkg;

  // bits 3:0 acc, 5:4 dma event/irq, 7:6 timer lo/hi
  typedef logic [`EU_EVT_W-1:0] eu_evt_t;

  typedef eu_evt_t [`NB_CORES-1:0] eu_evt_array_t;

  // word offset inside one core's register window
  typedef enum logic [1:0] {
    OFS_MASK   = 2'd0,
    OFS_BUFFER = 2'd1,
    OFS_CLEAR  = 2'd2
  } eu_ofs_e;

  // offset 3 has no register

endpackage

`default_nettype wire

//--- rtl/periph_stream_if.sv
/*
 * valid/ready stream
 * one payload per transfer, used between the internal pipeline stages
 */

`default_nettype none

interface periph_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

//--- rtl/eu_plug_merge.sv
/*
 * event unit plug merge
 * folds the two peripheral plugs into one request stream,
 * plug 0 wins whenever it requests
 */

`default_nettype none

`include "periph_consts.svh"

module eu_plug_merge
  import periph_bus_pkg::*;
(
  input  logic [1:0]                     plug_req_i,
  input  logic [1:0][`PERIPH_ADDR_W-1:0] plug_add_i,
  input  logic [1:0]                     plug_wen_i,
  input  logic [1:0][`PERIPH_DATA_W-1:0] plug_wdata_i,
  input  logic [1:0][`PERIPH_BE_W-1:0]   plug_be_i,
  input  logic [1:0][`PERIPH_ID_W-1:0]   plug_id_i,
  output logic [1:0]                     plug_gnt_o,

  periph_stream_if.source                req_o
);

  logic        sel_plug1;
  periph_req_t req;

  // plug 1 only when it is alone on the bus
  assign sel_plug1 = plug_req_i[1] & ~plug_req_i[0];

  always_comb begin
    req.add   = plug_add_i[sel_plug1];
    req.wen   = plug_wen_i[sel_plug1];
    req.wdata = plug_wdata_i[sel_plug1];
    req.be    = plug_be_i[sel_plug1];
    req.id    = plug_id_i[sel_plug1];
  end

  assign req_o.valid = |plug_req_i;
  assign req_o.data  = req;

  // ********************
  // grant back to the selected plug only
  // ********************

  // plug 0 is selected whenever it requests
  assign plug_gnt_o[0] = req_o.ready & plug_req_i[0];
  assign plug_gnt_o[1] = req_o.ready & sel_plug1;

endmodule

`default_nettype wire

//--- rtl/pipe_reg.sv
/*
 * pipeline register
 * one-entry valid/ready stage for any payload type
 */

`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic            clk_i,
  input  logic            arst_n_i,

  periph_stream_if.sink   in_i,
  periph_stream_if.source out_o
);

  logic     valid_q;
  payload_t data_q;

  // take new data while empty or while the held entry leaves
  assign in_i.ready = ~valid_q | out_o.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_i.ready) begin
      valid_q <= in_i.valid;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (in_i.valid && in_i.ready) begin
      data_q <= in_i.data;
    end
  end

  assign out_o.valid = valid_q;
  assign out_o.data  = data_q;

endmodule

`default_nettype wire

//--- rtl/event_buffer.sv
/*
 * event buffer
 * per-core sticky event buffer and event mask behind the peripheral bus,
 * drives one pending event line per core
 */

`default_nettype none

`include "periph_consts.svh"

module event_buffer
  import periph_bus_pkg::*;
  import event_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,

  periph_stream_if.sink                           req_i,
  periph_stream_if.source                         resp_o,

  input  logic [`NB_CORES-1:0][`EU_ACC_EVT_W-1:0] acc_events_i,
  input  logic                                    dma_event_i,
  input  logic                                    dma_irq_i,
  input  logic                                    timer_lo_i,
  input  logic                                    timer_hi_i,

  output logic [`NB_CORES-1:0]                    core_event_o
);

  localparam int unsigned CORE_SEL_W = $clog2(`NB_CORES);

  periph_req_t           req;
  periph_resp_t          resp;
  logic [`EU_CORE_W-1:0] core_idx;
  logic [CORE_SEL_W-1:0] core_sel;
  eu_ofs_e               ofs;
  logic                  addr_err;
  logic                  xfer;
  logic                  wr_en;
  eu_evt_t               wr_byte;

  eu_evt_array_t evt_vec;
  eu_evt_array_t mask_q;
  eu_evt_array_t mask_d;
  eu_evt_array_t buffer_q;
  eu_evt_array_t buffer_d;

  // ********************
  // event assembly
  // ********************

  // dma and timer events go to every core
  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      evt_vec[c] = {timer_hi_i, timer_lo_i, dma_irq_i, dma_event_i, acc_events_i[c]};
    end
  end

  // ********************
  // bus decode
  // ********************

  assign req      = req_i.data;
  assign core_idx = req.add[`EU_CORE_LSB +: `EU_CORE_W];
  assign core_sel = core_idx[CORE_SEL_W-1:0];
  assign ofs      = eu_ofs_e'(req.add[`EU_OFS_LSB +: $bits(eu_ofs_e)]);

  // no such core, or the unmapped offset
  assign addr_err = (core_idx >= `EU_CORE_W'(`NB_CORES)) ||
                    !(ofs inside {OFS_MASK, OFS_BUFFER, OFS_CLEAR});

  // the response side never pushes back, so neither does the request side
  assign req_i.ready = resp_o.ready;
  assign xfer        = req_i.valid & req_i.ready;
  assign wr_en       = xfer & ~req.wen & ~addr_err;
  assign wr_byte     = req.wdata[`EU_EVT_W-1:0];

  always_comb begin
    mask_d   = mask_q;
    buffer_d = buffer_q;
    if (wr_en && (ofs == OFS_MASK) && req.be[0]) begin
      mask_d[core_sel] = wr_byte;
    end
    if (wr_en && (ofs == OFS_CLEAR)) begin
      buffer_d[core_sel] = buffer_q[core_sel] & ~wr_byte;
    end
    // a new event beats a clear in the same cycle
    buffer_d = buffer_d | evt_vec;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q   <= '0;
      buffer_q <= '0;
    end else begin
      mask_q   <= mask_d;
      buffer_q <= buffer_d;
    end
  end

  // pending line per core
  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      core_event_o[c] = |(buffer_q[c] & mask_q[c]);
    end
  end

  // ********************
  // response
  // ********************

  always_comb begin
    resp.id    = req.id;
    resp.opc   = OPC_OK;
    resp.rdata = '0;
    if (addr_err) begin
      resp.opc = OPC_ERR;
    end else if (req.wen) begin
      case (ofs)
        OFS_MASK:   resp.rdata = `PERIPH_DATA_W'(mask_q[core_sel]);
        OFS_BUFFER: resp.rdata = `PERIPH_DATA_W'(buffer_q[core_sel]);
        // clear register reads back as zero
        default:    resp.rdata = '0;
      endcase
    end
  end

  assign resp_o.valid = req_i.valid;
  assign resp_o.data  = resp;

endmodule

`default_nettype wire

//--- rtl/cluster_event_top.sv
/*
 * cluster event top
 * two peripheral plugs merged into a request stage, the event buffer,
 * and a response stage broadcast back on both plugs
 */

`default_nettype none

`include "periph_consts.svh"

module cluster_event_top
  import periph_bus_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,

  // plug 0
  input  logic                                    plug0_req_i,
  input  logic [`PERIPH_ADDR_W-1:0]               plug0_add_i,
  input  logic                                    plug0_wen_i,
  input  logic [`PERIPH_DATA_W-1:0]               plug0_wdata_i,
  input  logic [`PERIPH_BE_W-1:0]                 plug0_be_i,
  input  logic [`PERIPH_ID_W-1:0]                 plug0_id_i,
  output logic                                    plug0_gnt_o,
  output logic                                    plug0_r_valid_o,
  output logic [`PERIPH_DATA_W-1:0]               plug0_r_rdata_o,
  output logic                                    plug0_r_opc_o,
  output logic [`PERIPH_ID_W-1:0]                 plug0_r_id_o,

  // plug 1
  input  logic                                    plug1_req_i,
  input  logic [`PERIPH_ADDR_W-1:0]               plug1_add_i,
  input  logic                                    plug1_wen_i,
  input  logic [`PERIPH_DATA_W-1:0]               plug1_wdata_i,
  input  logic [`PERIPH_BE_W-1:0]                 plug1_be_i,
  input  logic [`PERIPH_ID_W-1:0]                 plug1_id_i,
  output logic                                    plug1_gnt_o,
  output logic                                    plug1_r_valid_o,
  output logic [`PERIPH_DATA_W-1:0]               plug1_r_rdata_o,
  output logic                                    plug1_r_opc_o,
  output logic [`PERIPH_ID_W-1:0]                 plug1_r_id_o,

  // event sources
  input  logic [`NB_CORES-1:0][`EU_ACC_EVT_W-1:0] acc_events_i,
  input  logic                                    dma_event_i,
  input  logic                                    dma_irq_i,
  input  logic                                    timer_lo_i,
  input  logic                                    timer_hi_i,

  output logic [`NB_CORES-1:0]                    core_event_o
);

  logic [1:0]                     plug_req;
  logic [1:0][`PERIPH_ADDR_W-1:0] plug_add;
  logic [1:0]                     plug_wen;
  logic [1:0][`PERIPH_DATA_W-1:0] plug_wdata;
  logic [1:0][`PERIPH_BE_W-1:0]   plug_be;
  logic [1:0][`PERIPH_ID_W-1:0]   plug_id;
  logic [1:0]                     plug_gnt;

  periph_stream_if #(.payload_t(periph_req_t))  req_merged  ();
  periph_stream_if #(.payload_t(periph_req_t))  req_staged  ();
  periph_stream_if #(.payload_t(periph_resp_t)) resp_raw    ();
  periph_stream_if #(.payload_t(periph_resp_t)) resp_staged ();

  assign plug_req   = {plug1_req_i,   plug0_req_i};
  assign plug_add   = {plug1_add_i,   plug0_add_i};
  assign plug_wen   = {plug1_wen_i,   plug0_wen_i};
  assign plug_wdata = {plug1_wdata_i, plug0_wdata_i};
  assign plug_be    = {plug1_be_i,    plug0_be_i};
  assign plug_id    = {plug1_id_i,    plug0_id_i};

  assign plug0_gnt_o = plug_gnt[0];
  assign plug1_gnt_o = plug_gnt[1];

  // ********************
  // request path
  // ********************

  eu_plug_merge i_plug_merge (
    .plug_req_i   ( plug_req   ),
    .plug_add_i   ( plug_add   ),
    .plug_wen_i   ( plug_wen   ),
    .plug_wdata_i ( plug_wdata ),
    .plug_be_i    ( plug_be    ),
    .plug_id_i    ( plug_id    ),
    .plug_gnt_o   ( plug_gnt   ),
    .req_o        ( req_merged )
  );

  pipe_reg #(
    .payload_t ( periph_req_t )
  ) i_req_stage (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .in_i     ( req_merged ),
    .out_o    ( req_staged )
  );

  event_buffer i_event_buffer (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .req_i        ( req_staged   ),
    .resp_o       ( resp_raw     ),
    .acc_events_i ( acc_events_i ),
    .dma_event_i  ( dma_event_i  ),
    .dma_irq_i    ( dma_irq_i    ),
    .timer_lo_i   ( timer_lo_i   ),
    .timer_hi_i   ( timer_hi_i   ),
    .core_event_o ( core_event_o )
  );

  // ********************
  // response path
  // ********************

  pipe_reg #(
    .payload_t ( periph_resp_t )
  ) i_resp_stage (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .in_i     ( resp_raw    ),
    .out_o    ( resp_staged )
  );

  // the bus has no response back-pressure
  assign resp_staged.ready = 1'b1;

  // same response on both plugs, requester matches on r_id
  assign plug0_r_valid_o = resp_staged.valid;
  assign plug0_r_rdata_o = resp_staged.data.rdata;
  assign plug0_r_opc_o   = resp_staged.data.opc;
  assign plug0_r_id_o    = resp_staged.data.id;

  assign plug1_r_valid_o = resp_staged.valid;
  assign plug1_r_rdata_o = resp_staged.data.rdata;
  assign plug1_r_opc_o   = resp_staged.data.opc;
  assign plug1_r_id_o    = resp_staged.data.id;

endmodule

`default_nettype wire

//--- verification/tb_cluster_event.sv
/*
 * cluster event unit testbench
 * drives both plugs and the event inputs, checks every response and the
 * pending event lines against a reference model of the event buffer
 */

`default_nettype none

`include "periph_consts.svh"

module tb_cluster_event
  import periph_bus_pkg::*;
  import event_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned TIMEOUT_CYC = 50;
  localparam logic [`PERIPH_ADDR_W-1:0] EU_BASE = 32'h1020_0000;

  logic                                    clk;
  logic                                    arst_n;
  logic [1:0]                              plug_req;
  periph_req_t [1:0]                       plug_pkt;
  logic [`NB_CORES-1:0][`EU_ACC_EVT_W-1:0] acc_events;
  logic                                    dma_event;
  logic                                    dma_irq;
  logic                                    timer_lo;
  logic                                    timer_hi;

  wire [1:0]                               plug_gnt;
  wire [1:0]                               r_valid;
  wire [1:0][`PERIPH_DATA_W-1:0]           r_rdata;
  wire [1:0]                               r_opc;
  wire [1:0][`PERIPH_ID_W-1:0]             r_id;
  wire [`NB_CORES-1:0]                     core_event;

  // reference model state and expected responses in request order
  eu_evt_array_t mask_m;
  eu_evt_array_t buffer_m;
  periph_resp_t  exp_q[$];
  int unsigned   grant_cyc_q[$];
  int unsigned   cycle_cnt = 0;
  string         test_name = "reset";

  cluster_event_top i_dut (
    .clk_i           ( clk                 ),
    .arst_n_i        ( arst_n              ),
    .plug0_req_i     ( plug_req[0]         ),
    .plug0_add_i     ( plug_pkt[0].add     ),
    .plug0_wen_i     ( plug_pkt[0].wen     ),
    .plug0_wdata_i   ( plug_pkt[0].wdata   ),
    .plug0_be_i      ( plug_pkt[0].be      ),
    .plug0_id_i      ( plug_pkt[0].id      ),
    .plug0_gnt_o     ( plug_gnt[0]         ),
    .plug0_r_valid_o ( r_valid[0]          ),
    .plug0_r_rdata_o ( r_rdata[0]          ),
    .plug0_r_opc_o   ( r_opc[0]            ),
    .plug0_r_id_o    ( r_id[0]             ),
    .plug1_req_i     ( plug_req[1]         ),
    .plug1_add_i     ( plug_pkt[1].add     ),
    .plug1_wen_i     ( plug_pkt[1].wen     ),
    .plug1_wdata_i   ( plug_pkt[1].wdata   ),
    .plug1_be_i      ( plug_pkt[1].be      ),
    .plug1_id_i      ( plug_pkt[1].id      ),
    .plug1_gnt_o     ( plug_gnt[1]         ),
    .plug1_r_valid_o ( r_valid[1]          ),
    .plug1_r_rdata_o ( r_rdata[1]          ),
    .plug1_r_opc_o   ( r_opc[1]            ),
    .plug1_r_id_o    ( r_id[1]             ),
    .acc_events_i    ( acc_events          ),
    .dma_event_i     ( dma_event           ),
    .dma_irq_i       ( dma_irq             ),
    .timer_lo_i      ( timer_lo            ),
    .timer_hi_i      ( timer_hi            ),
    .core_event_o    ( core_event          )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // counted on the falling edge so rising-edge samplers see a stable value
  always @(negedge clk) cycle_cnt++;

  // ********************
  // reporting and compare tasks
  // ********************

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_resp(string name, periph_resp_t exp, periph_resp_t act);
    if (act !== exp) begin
      report_failure($sformatf(
        "FAIL %s: expected rdata=%h opc=%0d id=%h, actual rdata=%h opc=%0d id=%h",
        name, exp.rdata, exp.opc, exp.id, act.rdata, act.opc, act.id));
    end
  endtask

  task automatic check_events(string name, logic [`NB_CORES-1:0] exp,
                              logic [`NB_CORES-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected core_event=%b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_handshake(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // ********************
  // reference model
  // ********************

  // core index in add[7:4], word offset in add[3:2], wen low means write
  function automatic periph_resp_t ref_access(periph_req_t req);
    periph_resp_t resp;
    int unsigned  core;
    int unsigned  ofs;
    core       = req.add[`EU_CORE_LSB +: `EU_CORE_W];
    ofs        = req.add[`EU_OFS_LSB +: 2];
    resp.id    = req.id;
    resp.opc   = OPC_OK;
    resp.rdata = '0;
    if (core >= `NB_CORES || ofs == 3) begin
      resp.opc = OPC_ERR;
    end else if (!req.wen) begin
      if (ofs == 0 && req.be[0]) begin
        mask_m[core] = req.wdata[7:0];
      end
      if (ofs == 2) begin
        buffer_m[core] = buffer_m[core] & ~req.wdata[7:0];
      end
    end else if (ofs == 0) begin
      resp.rdata = {24'h0, mask_m[core]};
    end else if (ofs == 1) begin
      resp.rdata = {24'h0, buffer_m[core]};
    end
    return resp;
  endfunction

  // acc in bits 3:0, then dma event, dma irq, timer lo, timer hi
  function automatic eu_evt_t ref_evt_vec(logic [3:0] acc, logic [3:0] bcast);
    eu_evt_t v;
    v[3:0] = acc;
    v[4]   = bcast[0];
    v[5]   = bcast[1];
    v[6]   = bcast[2];
    v[7]   = bcast[3];
    return v;
  endfunction

  function automatic logic [`NB_CORES-1:0] ref_pending();
    logic [`NB_CORES-1:0] pend;
    for (int c = 0; c < `NB_CORES; c++) begin
      pend[c] = |(buffer_m[c] & mask_m[c]);
    end
    return pend;
  endfunction

  function automatic periph_resp_t read_resp(int p);
    periph_resp_t r;
    r.rdata = r_rdata[p];
    r.opc   = periph_opc_e'(r_opc[p]);
    r.id    = r_id[p];
    return r;
  endfunction

  function automatic periph_req_t make_req(int unsigned core, int unsigned ofs, logic wen,
                                           logic [31:0] wdata, logic [3:0] be,
                                           logic [8:0] id);
    periph_req_t r;
    r.add   = EU_BASE;
    r.add[`EU_CORE_LSB +: `EU_CORE_W] = `EU_CORE_W'(core);
    r.add[`EU_OFS_LSB +: 2] = 2'(ofs);
    r.wen   = wen;
    r.wdata = wdata;
    r.be    = be;
    r.id    = id;
    return r;
  endfunction

  // response compare, on both plugs since the response is broadcast
  initial begin : compare_responses
    periph_resp_t exp;
    logic         exp_valid;
    forever begin
      @(posedge clk);
      if (arst_n) begin
        // r_valid is due two cycles after the grant
        exp_valid = (grant_cyc_q.size() != 0) && (cycle_cnt - grant_cyc_q[0] == 2);
        check_handshake({test_name, " r_valid"}, {2{exp_valid}}, r_valid);
        if (exp_valid) begin
          exp = exp_q.pop_front();
          grant_cyc_q.delete(0);
          check_resp({test_name, " plug0"}, exp, read_resp(0));
          check_resp({test_name, " plug1"}, exp, read_resp(1));
        end
      end
    end
  end

  // ********************
  // drivers
  // ********************

  task automatic expect_resp(periph_req_t req);
    exp_q.push_back(ref_access(req));
    grant_cyc_q.push_back(cycle_cnt);
  endtask

  task automatic issue_req(int p, periph_req_t req);
    int unsigned wait_cyc;
    wait_cyc    = 0;
    plug_pkt[p] = req;
    plug_req[p] = 1'b1;
    @(posedge clk);
    while (!plug_gnt[p]) begin
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        report_failure($sformatf("timeout waiting for a grant on plug %0d", p));
      end
      @(posedge clk);
    end
    check_handshake({test_name, " gnt"}, 2'(1 << p), plug_gnt);
    expect_resp(req);
    #10;
    plug_req[p] = 1'b0;
  endtask

  // both plugs at once, plug 0 first, then plug 1 on its own
  task automatic merge_both(periph_req_t req0, periph_req_t req1);
    plug_pkt[0] = req0;
    plug_pkt[1] = req1;
    plug_req    = 2'b11;
    @(posedge clk);
    check_handshake({test_name, " both requesting"}, 2'b01, plug_gnt);
    expect_resp(req0);
    #10;
    plug_req[0] = 1'b0;
    @(posedge clk);
    check_handshake({test_name, " plug1 left"}, 2'b10, plug_gnt);
    expect_resp(req1);
    #10;
    plug_req[1] = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned wait_cyc;
    wait_cyc = 0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        report_failure("timeout waiting for the outstanding responses");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #10;
  endtask

  // one-cycle pulse, pending lines checked the cycle after capture
  task automatic pulse_events(logic [`NB_CORES-1:0][`EU_ACC_EVT_W-1:0] acc,
                              logic [3:0] bcast);
    acc_events = acc;
    {timer_hi, timer_lo, dma_irq, dma_event} = bcast;
    @(posedge clk);
    #10;
    acc_events = '0;
    {timer_hi, timer_lo, dma_irq, dma_event} = 4'h0;
    for (int c = 0; c < `NB_CORES; c++) begin
      buffer_m[c] = buffer_m[c] | ref_evt_vec(acc[c], bcast);
    end
    @(posedge clk);
    check_events(test_name, ref_pending(), core_event);
    #10;
  endtask

  // ********************
  // test sequence
  // ********************

  initial begin : main_sequence
    int unsigned core;
    void'($urandom(39885));
    arst_n     = 1'b0;
    plug_req   = '0;
    plug_pkt   = '0;
    acc_events = '0;
    dma_event  = 1'b0;
    dma_irq    = 1'b0;
    timer_lo   = 1'b0;
    timer_hi   = 1'b0;
    mask_m     = '0;
    buffer_m   = '0;
    repeat (10) @(posedge clk);
    #10;
    arst_n = 1'b1;

    test_name = "after_reset";
    @(posedge clk);
    check_handshake("after_reset gnt", 2'b00, plug_gnt);
    check_handshake("after_reset r_valid", 2'b00, r_valid);
    check_events("after_reset core_event", '0, core_event);
    #10;
    for (int c = 0; c < `NB_CORES; c++) begin
      issue_req(0, make_req(c, OFS_MASK, 1'b1, '0, 4'hf, 9'($urandom)));
      issue_req(0, make_req(c, OFS_BUFFER, 1'b1, '0, 4'hf, 9'($urandom)));
    end
    wait_idle();

    test_name = "mask_rw";
    repeat (24) begin
      core = $urandom_range(`NB_CORES-1);
      issue_req(0, make_req(core, OFS_MASK, 1'b0, $urandom, 4'($urandom), 9'($urandom)));
      issue_req(0, make_req(core, OFS_MASK, 1'b1, '0, 4'hf, 9'($urandom)));
    end
    wait_idle();

    test_name = "event_capture";
    for (int c = 0; c < `NB_CORES; c++) begin
      issue_req(0, make_req(c, OFS_MASK, 1'b0, $urandom, 4'h1, 9'($urandom)));
    end
    wait_idle();
    repeat (16) begin
      pulse_events($urandom & $urandom, 4'($urandom & $urandom));
    end
    for (int c = 0; c < `NB_CORES; c++) begin
      issue_req(0, make_req(c, OFS_BUFFER, 1'b1, '0, 4'hf, 9'($urandom)));
      issue_req(0, make_req(c, OFS_CLEAR, 1'b0, $urandom, 4'hf, 9'($urandom)));
      issue_req(0, make_req(c, OFS_CLEAR, 1'b1, '0, 4'hf, 9'($urandom)));
      issue_req(0, make_req(c, OFS_BUFFER, 1'b1, '0, 4'hf, 9'($urandom)));
    end
    wait_idle();
    @(posedge clk);
    check_events("event_capture after clear", ref_pending(), core_event);
    #10;

    test_name = "plug_merge";
    merge_both(make_req(1, OFS_MASK, 1'b1, '0, 4'hf, 9'h001),
               make_req(2, OFS_BUFFER, 1'b1, '0, 4'hf, 9'h100));
    issue_req(1, make_req(3, OFS_MASK, 1'b0, $urandom, 4'hf, 9'h102));
    issue_req(1, make_req(3, OFS_MASK, 1'b1, '0, 4'hf, 9'h104));
    wait_idle();

    test_name = "addr_errors";
    repeat (8) begin
      issue_req(0, make_req($urandom_range(15, 8), $urandom_range(3), 1'($urandom),
                            $urandom, 4'hf, 9'($urandom)));
      issue_req(0, make_req($urandom_range(7), 3, 1'($urandom), $urandom, 4'hf,
                            9'($urandom)));
    end
    wait_idle();

    // mixed traffic, one request granted per cycle
    test_name = "back_to_back";
    repeat (40) begin
      issue_req($urandom_range(1), make_req($urandom_range(9), $urandom_range(3),
                                            1'($urandom), $urandom, 4'($urandom),
                                            9'($urandom)));
    end
    wait_idle();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/periph_bus_pkg.sv
rtl/event_pkg.sv
rtl/periph_stream_if.sv
rtl/eu_plug_merge.sv
rtl/pipe_reg.sv
rtl/event_buffer.sv
rtl/cluster_event_top.sv
verification/tb_cluster_event.sv
